/* sim.f */
hdl/fifo_pkg.sv
hdl/gray_ptr.sv
hdl/fifo_slice.sv
hdl/rst_hold_timer.sv
hdl/fifo_rst_seq.sv
hdl/fifo_wide.sv
hdl/fifo_top.sv
tests/tb_fifo_top.sv

/* tests/tb_fifo_top.sv */
// Testbench for the dual-clock wide FIFO
// Both clocks run at 100 ns, rd_clk lags wr_clk by 37 ns
// Inputs change on falling edges, flags are sampled there too
// A queue models the FIFO contents, rows of a table drive the run

module tb_fifo_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DSIZE = 150;
    localparam int AW    = 4;
    localparam int HOLD  = 8;
    localparam int DEPTH = 1 << AW;

    logic             wr_clk;
    logic             rd_clk;
    logic             arst_n;
    logic [DSIZE-1:0] din;
    logic             wr_en;
    logic             rd_en;
    logic [DSIZE-1:0] dout;
    logic             full;
    logic             empty;
    fifo_pkg::count_t wrcount;
    fifo_pkg::count_t rdcount;
    logic             busy;

    // Reference model and bookkeeping
    logic [DSIZE-1:0] model_q [$];
    logic [DSIZE-1:0] exp_dout;
    string            cur_name;
    int               errors;
    int               checks;
    int               cycle_limit;
    int               cycles;

    // Stimulus table, one entry per row in each queue
    string row_name [$];
    int    row_wr [$];
    int    row_rd [$];
    bit    row_over [$];
    bit    row_rst [$];
    int    row_level [$];

    fifo_top #(
        .DSIZE       (DSIZE),
        .AW          (AW),
        .HOLD_CYCLES (HOLD)
    ) u_dut (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .arst_n  (arst_n),
        .din     (din),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .dout    (dout),
        .full    (full),
        .empty   (empty),
        .wrcount (wrcount),
        .rdcount (rdcount),
        .busy    (busy)
    );

    initial begin
        wr_clk = 1'b0;
        forever #50 wr_clk = ~wr_clk;
    end

    // Same period, offset so no edges coincide
    initial begin
        rd_clk = 1'b0;
        #37;
        forever #50 rd_clk = ~rd_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [DSIZE-1:0] random_word();
        logic [159:0] r;
        r = {$urandom, $urandom, $urandom, $urandom, $urandom};
        return r[DSIZE-1:0];
    endfunction

    task automatic check_value(input string what, input logic [DSIZE-1:0] exp,
                               input logic [DSIZE-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input int n_wr, input int n_rd,
                           input bit over, input bit mid_rst, input int level);
        row_name.push_back(name);
        row_wr.push_back(n_wr);
        row_rd.push_back(n_rd);
        row_over.push_back(over);
        row_rst.push_back(mid_rst);
        row_level.push_back(level);
    endtask

    // Holds arst_n low for 4 cycles, then waits for the sequencer
    task automatic apply_reset();
        int waited;
        arst_n = 1'b0;
        repeat (4) @(negedge wr_clk);
        check_value("busy in reset", 1, busy);
        check_value("full in reset", 1, full);
        check_value("empty in reset", 1, empty);
        check_value("wrcount in reset", 0, wrcount);
        check_value("rdcount in reset", 0, rdcount);
        check_value("dout in reset", 0, dout);
        arst_n = 1'b1;
        model_q.delete();
        exp_dout = '0;
        waited = 0;
        while (busy && waited < 2 + HOLD + 4) begin
            @(negedge wr_clk);
            waited++;
        end
        checks++;
        if (busy) begin
            errors++;
            $display("ERROR: %s busy still high %0d cycles after reset release",
                     cur_name, waited);
        end
        check_value("full after busy", 0, full);
        check_value("empty after busy", 1, empty);
        check_value("wrcount after busy", 0, wrcount);
        check_value("rdcount after busy", 0, rdcount);
        check_value("dout after busy", 0, dout);
    endtask

    // Overrun keeps wr_en high, else it waits for room
    task automatic write_words(input int n, input bit over);
        int               acc;
        int               tries;
        logic [DSIZE-1:0] w;
        acc   = 0;
        tries = 0;
        while ((over && tries < n) || (!over && acc < n)) begin
            @(negedge wr_clk);
            if (over || !full) begin
                w     = random_word();
                din   = w;
                wr_en = 1'b1;
                tries++;
                // full cannot change before the next rising edge
                if (!full) begin
                    model_q.push_back(w);
                    acc++;
                end
            end else begin
                wr_en = 1'b0;
            end
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    // dout is checked one rd_clk after every read attempt
    task automatic read_words(input int n, input bit over);
        int acc;
        int tries;
        acc   = 0;
        tries = 0;
        while ((over && tries < n) || (!over && acc < n)) begin
            @(negedge rd_clk);
            check_value("dout", exp_dout, dout);
            if (over || !empty) begin
                rd_en = 1'b1;
                tries++;
                if (!empty && model_q.size() == 0) begin
                    errors++;
                    $display("ERROR: %s read accepted with nothing written", cur_name);
                end else if (!empty) begin
                    exp_dout = model_q.pop_front();
                    acc++;
                end
            end else begin
                rd_en = 1'b0;
            end
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
        check_value("dout", exp_dout, dout);
    endtask

    task automatic settle_and_check(input int level);
        repeat (10) @(negedge wr_clk);
        check_value("model level", level, model_q.size());
        check_value("wrcount", model_q.size(), wrcount);
        check_value("rdcount", model_q.size(), rdcount);
        check_value("empty", model_q.size() == 0, empty);
        check_value("full", model_q.size() == DEPTH, full);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run
    ////////////////////////////////////////////////////////////////////////////

    // Limit from the table, doubled for margin
    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge wr_clk);
            cycles++;
        end
        $display("ERROR: timeout, run exceeded %0d write clock cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int sum;
        arst_n   = 1'b0;
        din      = '0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        errors   = 0;
        checks   = 0;
        exp_dout = '0;
        void'($urandom(32'hccb03779));

        // Name, writes, reads, overrun, mid reset, level after
        add_row("stream_8", 8, 8, 1'b0, 1'b0, 0);
        add_row("stream_40", 40, 40, 1'b0, 1'b0, 0);
        add_row("fill_past_full", 20, 0, 1'b1, 1'b0, DEPTH);
        add_row("drain_past_empty", 0, 20, 1'b1, 1'b0, 0);
        add_row("partial_6", 6, 2, 1'b0, 1'b0, 4);
        add_row("reset_mid", 5, 3, 1'b1, 1'b1, 0);
        add_row("after_reset", 12, 12, 1'b0, 1'b0, 0);

        sum = 0;
        foreach (row_name[i]) begin
            sum += row_wr[i] + row_rd[i] + 40;
        end
        cycle_limit = 2 * sum;

        cur_name = "power_on";
        apply_reset();

        foreach (row_name[i]) begin
            cur_name = row_name[i];
            if (row_rst[i]) begin
                // Flush between the writes and the reads
                write_words(row_wr[i], row_over[i]);
                apply_reset();
                read_words(row_rd[i], row_over[i]);
            end else begin
                fork
                    write_words(row_wr[i], row_over[i]);
                    read_words(row_rd[i], row_over[i]);
                join
            end
            settle_and_check(row_level[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* hdl/fifo_top.sv */
// Top level of the dual-clock wide FIFO
// Depth is 2**AW words of DSIZE bits
// full reads as 1 while the reset sequence is busy
// Writes and reads given against full or empty are ignored

module fifo_top #(
    parameter int DSIZE       = 150,
    parameter int AW          = 4,
    parameter int HOLD_CYCLES = 8
) (
    input  logic             wr_clk,
    input  logic             rd_clk,
    input  logic             arst_n,
    input  logic [DSIZE-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [DSIZE-1:0] dout,
    output logic             full,
    output logic             empty,
    output fifo_pkg::count_t wrcount,
    output fifo_pkg::count_t rdcount,
    output logic             busy
);

    logic                 timer_start;
    logic                 timer_done;
    logic                 wr_rst;
    logic                 rd_rst;
    fifo_pkg::wr_status_t wr_status;
    fifo_pkg::rd_status_t rd_status;

    fifo_rst_seq u_rst_seq (
        .wr_clk      (wr_clk),
        .rd_clk      (rd_clk),
        .arst_n      (arst_n),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .wr_rst      (wr_rst),
        .rd_rst      (rd_rst),
        .busy        (busy)
    );

    rst_hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold_timer (
        .wr_clk (wr_clk),
        .arst_n (arst_n),
        .start  (timer_start),
        .done   (timer_done)
    );

    fifo_wide #(
        .DSIZE (DSIZE),
        .AW    (AW)
    ) u_fifo_wide (
        .wr_clk    (wr_clk),
        .wr_rst    (wr_rst),
        .rd_clk    (rd_clk),
        .rd_rst    (rd_rst),
        .din       (din),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .dout      (dout),
        .wr_status (wr_status),
        .rd_status (rd_status)
    );

    // No room for writes until the sequence ends
    assign full    = wr_status.full | busy;
    assign wrcount = wr_status.wrcount;
    assign empty   = rd_status.empty;
    assign rdcount = rd_status.rdcount;

endmodule

/* hdl/fifo_wide.sv */
// Wide dual-clock FIFO built from 64-bit slices plus one remainder slice
// Slice 0 takes the top 64 bits of din, the remainder takes the low bits
// All slices share the enables and move together
// Status is taken from slice 0 only

module fifo_wide #(
    parameter int DSIZE = 150,
    parameter int AW    = 4
) (
    input  logic                 wr_clk,
    input  logic                 wr_rst,
    input  logic                 rd_clk,
    input  logic                 rd_rst,
    input  logic [DSIZE-1:0]     din,
    input  logic                 wr_en,
    input  logic                 rd_en,
    output logic [DSIZE-1:0]     dout,
    output fifo_pkg::wr_status_t wr_status,
    output fifo_pkg::rd_status_t rd_status
);

    localparam int SW  = fifo_pkg::SLICE_W;
    // Full slices and leftover bits
    localparam int N64 = DSIZE / SW;
    localparam int REM = DSIZE % SW;
    localparam int NSL = N64 + ((REM != 0) ? 1 : 0);

    fifo_pkg::wr_status_t slice_wr_status [NSL];
    fifo_pkg::rd_status_t slice_rd_status [NSL];

    genvar k;

    ////////////////////////////////////////////////////////////////////////////
    // Full 64-bit slices, most significant first
    ////////////////////////////////////////////////////////////////////////////
    for (k = 0; k < N64; k++) begin : g_slice
        fifo_slice #(
            .W  (SW),
            .AW (AW)
        ) u_slice (
            .wr_clk    (wr_clk),
            .wr_rst    (wr_rst),
            .rd_clk    (rd_clk),
            .rd_rst    (rd_rst),
            .din       (din[DSIZE-1-k*SW -: SW]),
            .wr_en     (wr_en),
            .rd_en     (rd_en),
            .dout      (dout[DSIZE-1-k*SW -: SW]),
            .wr_status (slice_wr_status[k]),
            .rd_status (slice_rd_status[k])
        );
    end

    // Remainder slice on the low bits
    if (REM != 0) begin : g_rem
        fifo_slice #(
            .W  (REM),
            .AW (AW)
        ) u_slice (
            .wr_clk    (wr_clk),
            .wr_rst    (wr_rst),
            .rd_clk    (rd_clk),
            .rd_rst    (rd_rst),
            .din       (din[REM-1:0]),
            .wr_en     (wr_en),
            .rd_en     (rd_en),
            .dout      (dout[REM-1:0]),
            .wr_status (slice_wr_status[N64]),
            .rd_status (slice_rd_status[N64])
        );
    end

    // Slices agree, first one reports
    assign wr_status = slice_wr_status[0];
    assign rd_status = slice_rd_status[0];

endmodule

/* hdl/fifo_rst_seq.sv */
// Reset sequencer for the dual-clock FIFO
// arst_n asserts both slice resets at once, release is synchronous
// Write side releases on entry to RST_DONE, read side 2 rd_clk later
// busy is high from arst_n low until RST_DONE

module fifo_rst_seq (
    input  logic wr_clk,
    input  logic rd_clk,
    input  logic arst_n,
    input  logic timer_done,
    output logic timer_start,
    output logic wr_rst,
    output logic rd_rst,
    output logic busy
);

    logic [1:0]           wr_sync;
    logic                 wr_rst_n;
    logic [1:0]           rd_sync;
    fifo_pkg::rst_state_t state;
    fifo_pkg::rst_state_t state_next;

    // Async assert, sync release into wr_clk
    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_sync <= 2'b00;
        end else begin
            wr_sync <= {wr_sync[0], 1'b1};
        end
    end

    assign wr_rst_n = wr_sync[1];

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            fifo_pkg::RST_IDLE:   state_next = fifo_pkg::RST_ASSERT;
            fifo_pkg::RST_ASSERT: state_next = fifo_pkg::RST_HOLD;
            // Wait for the timer
            fifo_pkg::RST_HOLD: begin
                if (timer_done) begin
                    state_next = fifo_pkg::RST_DONE;
                end
            end
            default:              state_next = fifo_pkg::RST_DONE;
        endcase
    end

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            state  <= fifo_pkg::RST_IDLE;
            wr_rst <= 1'b1;
        end else begin
            state  <= state_next;
            wr_rst <= (state_next != fifo_pkg::RST_DONE);
        end
    end

    assign timer_start = (state == fifo_pkg::RST_HOLD);
    assign busy        = (state != fifo_pkg::RST_DONE);

    // Carry the release into rd_clk, assert still follows arst_n
    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_sync <= 2'b00;
        end else begin
            rd_sync <= {rd_sync[0], ~wr_rst};
        end
    end

    assign rd_rst = ~rd_sync[1];

endmodule

/* hdl/rst_hold_timer.sv */
// Reset hold timer in the write clock domain
// done pulses for one cycle HOLD_CYCLES clocks after start rises
// HOLD_CYCLES must be 1 or more and fit in 16 bits

module rst_hold_timer #(
    parameter int HOLD_CYCLES = 8
) (
    input  logic wr_clk,
    input  logic arst_n,
    input  logic start,
    output logic done
);

    localparam fifo_pkg::hold_cnt_t HOLD_LAST = fifo_pkg::hold_cnt_t'(HOLD_CYCLES - 1);
    localparam fifo_pkg::hold_cnt_t HOLD_END  = fifo_pkg::hold_cnt_t'(HOLD_CYCLES);

    fifo_pkg::hold_cnt_t cnt;

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (!start) begin
            // Idle, ready for the next start
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= (cnt == HOLD_LAST);
            // Saturate so done fires only once per start
            if (cnt != HOLD_END) begin
                cnt <= cnt + 16'd1;
            end
        end
    end

endmodule

/* hdl/fifo_slice.sv */
// One dual-clock FIFO slice of 2**AW words of W bits
// Standard read mode: dout loads at the rd_clk edge that accepts a read
// Flags are pessimistic, the far pointer arrives 2 to 3 clocks late
// wr_rst and rd_rst are active high, one per clock domain
// dout clears on rd_rst, memory contents are not cleared

module fifo_slice #(
    parameter int W  = 64,
    parameter int AW = 4
) (
    input  logic                 wr_clk,
    input  logic                 wr_rst,
    input  logic                 rd_clk,
    input  logic                 rd_rst,
    input  logic [W-1:0]         din,
    input  logic                 wr_en,
    input  logic                 rd_en,
    output logic [W-1:0]         dout,
    output fifo_pkg::wr_status_t wr_status,
    output fifo_pkg::rd_status_t rd_status
);

    localparam int DEPTH = 1 << AW;

    logic [W-1:0] mem [0:DEPTH-1];

    // Write side pointers
    logic [AW:0] wr_bin;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_far_bin;
    // Read side pointers
    logic [AW:0] rd_bin;
    logic [AW:0] rd_gray;
    logic [AW:0] wr_far_bin;

    logic        full;
    logic        empty;
    logic        wr_accept;
    logic        rd_accept;
    logic [AW:0] wr_diff;
    logic [AW:0] rd_diff;

    ////////////////////////////////////////////////////////////////////////////
    // Write domain
    ////////////////////////////////////////////////////////////////////////////

    // Same index, opposite wrap bit
    assign full      = (wr_bin == {~rd_far_bin[AW], rd_far_bin[AW-1:0]});
    assign wr_accept = wr_en & ~full;
    assign wr_diff   = wr_bin - rd_far_bin;

    gray_ptr #(
        .AW (AW)
    ) u_wr_ptr (
        .clk       (wr_clk),
        .rst       (wr_rst),
        .inc       (wr_accept),
        .bin       (wr_bin),
        .gray      (wr_gray),
        .gray_sync (rd_gray),
        .far_bin   (rd_far_bin)
    );

    always_ff @(posedge wr_clk) begin
        if (wr_accept) begin
            mem[wr_bin[AW-1:0]] <= din;
        end
    end

    assign wr_status.full    = full;
    assign wr_status.wrcount = fifo_pkg::count_t'(wr_diff);

    ////////////////////////////////////////////////////////////////////////////
    // Read domain
    ////////////////////////////////////////////////////////////////////////////

    assign empty     = (rd_bin == wr_far_bin);
    assign rd_accept = rd_en & ~empty;
    assign rd_diff   = wr_far_bin - rd_bin;

    gray_ptr #(
        .AW (AW)
    ) u_rd_ptr (
        .clk       (rd_clk),
        .rst       (rd_rst),
        .inc       (rd_accept),
        .bin       (rd_bin),
        .gray      (rd_gray),
        .gray_sync (wr_gray),
        .far_bin   (wr_far_bin)
    );

    // Registered read, holds its value while no read is accepted
    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            dout <= '0;
        end else if (rd_accept) begin
            dout <= mem[rd_bin[AW-1:0]];
        end
    end

    assign rd_status.empty   = empty;
    assign rd_status.rdcount = fifo_pkg::count_t'(rd_diff);

endmodule

/* hdl/gray_ptr.sv */
// Binary/gray pointer for one side of a dual-clock FIFO
// Pointer is AW+1 bits, the extra top bit tells a full ring from an empty one
// rst is active high, asserted asynchronously, released in clk domain
// Far gray pointer must change one bit at a time for the sync to be safe

module gray_ptr #(
    parameter int AW = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inc,
    output logic [AW:0] bin,
    output logic [AW:0] gray,
    input  logic [AW:0] gray_sync,
    output logic [AW:0] far_bin
);

    logic [AW:0] bin_next;
    logic [AW:0] sync_q1;
    logic [AW:0] sync_q2;

    // Advance by one on an accepted access
    assign bin_next = bin + {{AW{1'b0}}, inc};

    // Own pointer, binary for addressing, gray for the far domain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bin  <= '0;
            gray <= '0;
        end else begin
            bin  <= bin_next;
            gray <= bin_next ^ (bin_next >> 1);
        end
    end

    // Two-flop sync of the far gray pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gray_sync;
            sync_q2 <= sync_q1;
        end
    end

    // Gray to binary, top bit down
    always_comb begin
        far_bin[AW] = sync_q2[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            far_bin[i] = far_bin[i+1] ^ sync_q2[i];
        end
    end

endmodule

/* hdl/fifo_pkg.sv */
// Shared types for the dual-clock wide FIFO
// Occupancy counts are CNT_W bits wide, so slice depth exponent AW
// must not exceed CNT_W - 1
// Status structs carry the flag in the top bit, count below it

package fifo_pkg;

    // Width of every occupancy count
    localparam int CNT_W   = 14;
    // Width of one full data slice
    localparam int SLICE_W = 64;

    // Words stored, as seen from one clock domain
    typedef logic [CNT_W-1:0] count_t;
    // Reset hold timer value
    typedef logic [15:0]      hold_cnt_t;

    // Reset sequencer states
    typedef enum logic [1:0] {
        RST_IDLE,
        RST_ASSERT,
        RST_HOLD,
        RST_DONE
    } rst_state_t;

    // Write-domain status
    typedef struct packed {
        logic   full;
        count_t wrcount;
    } wr_status_t;

    // Read-domain status
    typedef struct packed {
        logic   empty;
        count_t rdcount;
    } rd_status_t;

endpackage
